/* common/lc3b_defines.svh */
`ifndef LC3B_DEFINES_SVH
`define LC3B_DEFINES_SVH

`define LC3B_WORD_W   16
`define LC3B_RESET_PC 16'h0000

// standard LC-3b opcode field values
`define LC3B_OP_BR  4'b0000
`define LC3B_OP_ADD 4'b0001
`define LC3B_OP_AND 4'b0101
`define LC3B_OP_LDR 4'b0110
`define LC3B_OP_STR 4'b0111
`define LC3B_OP_NOT 4'b1001
`define LC3B_OP_JMP 4'b1100
`define LC3B_OP_LEA 4'b1110

`define LC3B_ALU_ADD  2'd0
`define LC3B_ALU_AND  2'd1
`define LC3B_ALU_NOT  2'd2
`define LC3B_ALU_PASS 2'd3

`define LC3B_PCMUX_PLUS2 2'd0
`define LC3B_PCMUX_BR    2'd1
`define LC3B_PCMUX_ALU   2'd2 // jmp target comes through the alu as a pass

`define LC3B_ALUMUX_SR2  2'd0
`define LC3B_ALUMUX_ADJ6 2'd1
`define LC3B_ALUMUX_IMM5 2'd2

`define LC3B_REGFILEMUX_ALU    2'd0
`define LC3B_REGFILEMUX_MDR    2'd1
`define LC3B_REGFILEMUX_BR_ADD 2'd2

`define LC3B_MARMUX_ALU 1'b0
`define LC3B_MARMUX_PC  1'b1

`define LC3B_MDRMUX_ALU 1'b0
`define LC3B_MDRMUX_MEM 1'b1

`endif

/* common/lc3b_types.sv */
`default_nettype none

`include "lc3b_defines.svh"

package lc3b_types;

	typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [3:0] lc3b_opcode;
	typedef logic [1:0] lc3b_aluop;
	typedef logic [1:0] lc3b_sel;
	typedef logic [5:0] lc3b_offset6; // raw field, before extension
	typedef logic [8:0] lc3b_offset9;
	typedef logic [2:0] lc3b_nzp;

	// one clock per state, see the control unit for the sequence
	typedef enum logic [3:0]
	{
		FETCH1,
		FETCH2,
		FETCH3,
		DECODE,
		S_ALU,
		S_BR,
		S_JMP,
		S_LEA,
		CALC_ADDR,
		LDR1,
		LDR2,
		STR1,
		STR2
	} lc3b_state;

endpackage : lc3b_types

`default_nettype wire

/* datapath/lc3b_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_defines.svh"

module lc3b_alu
(
	input wire lc3b_types::lc3b_aluop aluop,
	input wire lc3b_types::lc3b_word a,
	input wire lc3b_types::lc3b_word b,
	output lc3b_types::lc3b_word f
);

	import lc3b_types::*;

	always_comb
	begin
		case (aluop)
			`LC3B_ALU_ADD: f = a + b;
			`LC3B_ALU_AND: f = a & b;
			`LC3B_ALU_NOT: f = ~a;
			default: f = a; // pass, used for jmp targets and store data
		endcase
	end

endmodule : lc3b_alu

`default_nettype wire

/* datapath/lc3b_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_regfile
(
	input wire clk,
	input wire rst_n,
	input wire load,
	input wire lc3b_types::lc3b_word in,
	input wire lc3b_types::lc3b_reg src_a,
	input wire lc3b_types::lc3b_reg src_b,
	input wire lc3b_types::lc3b_reg dest,
	output lc3b_types::lc3b_word reg_a,
	output lc3b_types::lc3b_word reg_b
);

	import lc3b_types::*;

	lc3b_word regs [8];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end
		else if (load)
			regs[dest] <= in;
	end

	assign reg_a = regs[src_a]; // reads see the old value during a write
	assign reg_b = regs[src_b];

endmodule : lc3b_regfile

`default_nettype wire

/* datapath/lc3b_ir.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_ir
(
	input wire clk,
	input wire rst_n,
	input wire load,
	input wire lc3b_types::lc3b_word in,
	output lc3b_types::lc3b_opcode opcode,
	output lc3b_types::lc3b_reg dest,
	output lc3b_types::lc3b_reg src1,
	output lc3b_types::lc3b_reg src2,
	output logic immediate,
	output lc3b_types::lc3b_word imm5,
	output lc3b_types::lc3b_word offset6,
	output lc3b_types::lc3b_word offset9
);

	import lc3b_types::*;

	lc3b_word data;
	lc3b_offset6 raw6;
	lc3b_offset9 raw9;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			data <= '0;
		else if (load)
			data <= in;
	end

	assign opcode = data[15:12];
	assign dest = data[11:9]; // also the nzp mask of a branch
	assign src1 = data[8:6];
	assign src2 = data[2:0];
	assign immediate = data[5];
	assign raw6 = data[5:0];
	assign raw9 = data[8:0];

	assign imm5 = {{11{data[4]}}, data[4:0]};
	// word addressing, so both offsets count in units of two bytes
	assign offset6 = {{9{raw6[5]}}, raw6, 1'b0};
	assign offset9 = {{6{raw9[8]}}, raw9, 1'b0};

endmodule : lc3b_ir

`default_nettype wire

/* datapath/lc3b_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_defines.svh"

module lc3b_datapath
(
	input wire clk,
	input wire rst_n,
	input wire load_pc,
	input wire load_ir,
	input wire load_regfile,
	input wire load_mar,
	input wire load_mdr,
	input wire load_cc,
	input wire lc3b_types::lc3b_sel pcmux_sel,
	input wire lc3b_types::lc3b_sel alumux_sel,
	input wire lc3b_types::lc3b_sel regfilemux_sel,
	input wire storemux_sel,
	input wire marmux_sel,
	input wire mdrmux_sel,
	input wire lc3b_types::lc3b_aluop aluop,
	input wire lc3b_types::lc3b_word mem_rdata,
	output lc3b_types::lc3b_opcode opcode,
	output logic immediate,
	output logic branch_enable,
	output lc3b_types::lc3b_word mem_address,
	output lc3b_types::lc3b_word mem_wdata
);

	import lc3b_types::*;

	lc3b_word pc, mar, mdr;
	lc3b_word pc_plus2, br_add;
	lc3b_word pcmux_out, alumux_out, regfilemux_out, marmux_out, mdrmux_out;
	lc3b_word alu_out, reg_a, reg_b;
	lc3b_word imm5, adj6, adj9;
	lc3b_reg dest, src1, src2, storemux_out;
	lc3b_nzp cc, gencc;

	assign pc_plus2 = pc + 16'd2;
	assign br_add = pc + adj9; // pc already points past the instruction here
	assign storemux_out = storemux_sel ? dest : src1;
	assign marmux_out = (marmux_sel == `LC3B_MARMUX_PC) ? pc : alu_out;
	assign mdrmux_out = (mdrmux_sel == `LC3B_MDRMUX_MEM) ? mem_rdata : alu_out;

	always_comb
	begin
		case (pcmux_sel)
			`LC3B_PCMUX_BR: pcmux_out = br_add;
			`LC3B_PCMUX_ALU: pcmux_out = alu_out;
			default: pcmux_out = pc_plus2;
		endcase
		case (alumux_sel)
			`LC3B_ALUMUX_ADJ6: alumux_out = adj6;
			`LC3B_ALUMUX_IMM5: alumux_out = imm5;
			default: alumux_out = reg_b;
		endcase
		case (regfilemux_sel)
			`LC3B_REGFILEMUX_MDR: regfilemux_out = mdr;
			`LC3B_REGFILEMUX_BR_ADD: regfilemux_out = br_add;
			default: regfilemux_out = alu_out;
		endcase
	end

	// condition codes come from whatever value is headed for the register file
	assign gencc[2] = regfilemux_out[`LC3B_WORD_W-1];
	assign gencc[1] = (regfilemux_out == '0);
	assign gencc[0] = !regfilemux_out[`LC3B_WORD_W-1] && (regfilemux_out != '0);

	assign branch_enable = |(dest & cc); // the nzp field shares bits 11:9 with dest

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pc <= `LC3B_RESET_PC;
			mar <= '0;
			mdr <= '0;
			cc <= '0;
		end
		else
		begin
			if (load_pc)
				pc <= pcmux_out;
			if (load_mar)
				mar <= marmux_out;
			if (load_mdr)
				mdr <= mdrmux_out;
			if (load_cc)
				cc <= gencc;
		end
	end

	assign mem_address = mar;
	assign mem_wdata = mdr;

	lc3b_ir i_lc3b_ir
	(
		.clk, .rst_n,
		.load(load_ir),
		.in(mdr),
		.opcode, .dest, .src1, .src2, .immediate,
		.imm5,
		.offset6(adj6),
		.offset9(adj9)
	);

	lc3b_regfile i_lc3b_regfile
	(
		.clk, .rst_n,
		.load(load_regfile),
		.in(regfilemux_out),
		.src_a(storemux_out),
		.src_b(src2),
		.dest,
		.reg_a, .reg_b
	);

	lc3b_alu i_lc3b_alu
	(
		.aluop,
		.a(reg_a),
		.b(alumux_out),
		.f(alu_out)
	);

endmodule : lc3b_datapath

`default_nettype wire

/* control/lc3b_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_defines.svh"

module lc3b_control
(
	input wire clk,
	input wire rst_n,
	input wire lc3b_types::lc3b_opcode opcode,
	input wire immediate,
	input wire branch_enable,
	output logic load_pc,
	output logic load_ir,
	output logic load_regfile,
	output logic load_mar,
	output logic load_mdr,
	output logic load_cc,
	output lc3b_types::lc3b_sel pcmux_sel,
	output lc3b_types::lc3b_sel alumux_sel,
	output lc3b_types::lc3b_sel regfilemux_sel,
	output logic storemux_sel,
	output logic marmux_sel,
	output logic mdrmux_sel,
	output lc3b_types::lc3b_aluop aluop,
	output logic mem_read,
	output logic mem_write
);

	import lc3b_types::*;

	lc3b_state state;
	lc3b_state state_next;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= FETCH1;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = FETCH1; // every execute state returns here
		case (state)
			FETCH1: state_next = FETCH2;
			FETCH2: state_next = FETCH3;
			FETCH3: state_next = DECODE;
			DECODE:
			begin
				case (opcode)
					`LC3B_OP_ADD, `LC3B_OP_AND, `LC3B_OP_NOT: state_next = S_ALU;
					`LC3B_OP_BR: state_next = S_BR;
					`LC3B_OP_JMP: state_next = S_JMP;
					`LC3B_OP_LEA: state_next = S_LEA;
					`LC3B_OP_LDR, `LC3B_OP_STR: state_next = CALC_ADDR;
					default: state_next = FETCH1; // unsupported opcodes act as a nop
				endcase
			end
			CALC_ADDR: state_next = (opcode == `LC3B_OP_LDR) ? LDR1 : STR1;
			LDR1: state_next = LDR2;
			STR1: state_next = STR2;
			default: state_next = FETCH1;
		endcase
	end

	always_comb
	begin
		load_pc = 1'b0;
		load_ir = 1'b0;
		load_regfile = 1'b0;
		load_mar = 1'b0;
		load_mdr = 1'b0;
		load_cc = 1'b0;
		pcmux_sel = `LC3B_PCMUX_PLUS2;
		alumux_sel = `LC3B_ALUMUX_SR2;
		regfilemux_sel = `LC3B_REGFILEMUX_ALU;
		storemux_sel = 1'b0;
		marmux_sel = `LC3B_MARMUX_ALU;
		mdrmux_sel = `LC3B_MDRMUX_ALU;
		aluop = `LC3B_ALU_PASS;
		mem_read = 1'b0;
		mem_write = 1'b0;

		case (state)
			FETCH1:
			begin
				marmux_sel = `LC3B_MARMUX_PC;
				load_mar = 1'b1;
				load_pc = 1'b1; // pc moves on to pc+2 in the same edge
			end
			FETCH2:
			begin
				mem_read = 1'b1;
				mdrmux_sel = `LC3B_MDRMUX_MEM;
				load_mdr = 1'b1;
			end
			FETCH3: load_ir = 1'b1;
			S_ALU:
			begin
				case (opcode)
					`LC3B_OP_AND: aluop = `LC3B_ALU_AND;
					`LC3B_OP_NOT: aluop = `LC3B_ALU_NOT;
					default: aluop = `LC3B_ALU_ADD;
				endcase
				alumux_sel = immediate ? `LC3B_ALUMUX_IMM5 : `LC3B_ALUMUX_SR2;
				load_regfile = 1'b1;
				load_cc = 1'b1;
			end
			S_BR:
			begin
				pcmux_sel = `LC3B_PCMUX_BR;
				load_pc = branch_enable;
			end
			S_JMP:
			begin
				pcmux_sel = `LC3B_PCMUX_ALU; // base register passes through the alu
				load_pc = 1'b1;
			end
			S_LEA:
			begin
				regfilemux_sel = `LC3B_REGFILEMUX_BR_ADD;
				load_regfile = 1'b1;
				load_cc = 1'b1;
			end
			CALC_ADDR:
			begin
				alumux_sel = `LC3B_ALUMUX_ADJ6;
				aluop = `LC3B_ALU_ADD;
				load_mar = 1'b1;
			end
			LDR1:
			begin
				mem_read = 1'b1;
				mdrmux_sel = `LC3B_MDRMUX_MEM;
				load_mdr = 1'b1;
			end
			LDR2:
			begin
				regfilemux_sel = `LC3B_REGFILEMUX_MDR;
				load_regfile = 1'b1;
				load_cc = 1'b1;
			end
			STR1:
			begin
				storemux_sel = 1'b1; // the source of a store sits in the dest field
				load_mdr = 1'b1;
			end
			STR2: mem_write = 1'b1;
			default:
			begin
			end
		endcase
	end

endmodule : lc3b_control

`default_nettype wire

/* verilog/lc3b_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_cpu
(
	input wire clk,
	input wire rst_n,
	input wire lc3b_types::lc3b_word mem_rdata,
	output logic mem_read,
	output logic mem_write,
	output lc3b_types::lc3b_word mem_address,
	output lc3b_types::lc3b_word mem_wdata
);

	import lc3b_types::*;

	logic load_pc;
	logic load_ir;
	logic load_regfile;
	logic load_mar;
	logic load_mdr;
	logic load_cc;
	lc3b_sel pcmux_sel;
	lc3b_sel alumux_sel;
	lc3b_sel regfilemux_sel;
	logic storemux_sel;
	logic marmux_sel;
	logic mdrmux_sel;
	lc3b_aluop aluop;
	lc3b_opcode opcode;
	logic immediate;
	logic branch_enable;

	lc3b_control i_lc3b_control
	(
		.clk, .rst_n,
		.opcode, .immediate, .branch_enable,
		.load_pc, .load_ir, .load_regfile, .load_mar, .load_mdr, .load_cc,
		.pcmux_sel, .alumux_sel, .regfilemux_sel,
		.storemux_sel, .marmux_sel, .mdrmux_sel,
		.aluop, .mem_read, .mem_write
	);

	lc3b_datapath i_lc3b_datapath
	(
		.clk, .rst_n,
		.load_pc, .load_ir, .load_regfile, .load_mar, .load_mdr, .load_cc,
		.pcmux_sel, .alumux_sel, .regfilemux_sel,
		.storemux_sel, .marmux_sel, .mdrmux_sel,
		.aluop, .mem_rdata,
		.opcode, .immediate, .branch_enable,
		.mem_address, .mem_wdata
	);

endmodule : lc3b_cpu

`default_nettype wire

/* bench/lc3b_cpu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_cpu_checker
(
	input wire clk,
	input wire rst_n,
	input wire lc3b_types::lc3b_state state,
	input wire mem_read,
	input wire mem_write,
	input wire load_ir
);

	import lc3b_types::*;

	a_no_read_and_write: assert property (@(posedge clk) !(mem_read && mem_write))
		else $error("mem_read and mem_write are high together");

	// the first cycle after reset is where rst_n is seen rising
	a_no_write_in_reset: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> !mem_write)
		else $error("mem_write high during or right after reset");

	a_fetch1_to_fetch2: assert property (@(posedge clk) disable iff (!rst_n)
		state == FETCH1 |=> state == FETCH2)
		else $error("state after FETCH1 is not FETCH2");

	a_load_ir_in_fetch3: assert property (@(posedge clk) load_ir |-> state == FETCH3)
		else $error("load_ir outside FETCH3");

endmodule

bind lc3b_control lc3b_cpu_checker i_lc3b_cpu_checker
(
	.clk(clk),
	.rst_n(rst_n),
	.state(state),
	.mem_read(mem_read),
	.mem_write(mem_write),
	.load_ir(load_ir)
);

`default_nettype wire

/* bench/lc3b_cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_cpu_tb;

	import lc3b_types::*;

	localparam string STIM_FILE = "bench/lc3b_stim.txt";
	localparam int MEM_WORDS = 32768;

	logic clk;
	logic rst_n;
	lc3b_word mem_rdata;
	logic mem_read;
	logic mem_write;
	lc3b_word mem_address;
	lc3b_word mem_wdata;

	lc3b_word mem [MEM_WORDS];
	lc3b_word exp_addr [$];
	lc3b_word exp_data [$];
	int instr_count;
	int store_count;
	int cycles;
	int cycle_limit;

	lc3b_cpu i_lc3b_cpu
	(
		.clk(clk),
		.rst_n(rst_n),
		.mem_rdata(mem_rdata),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_address(mem_address),
		.mem_wdata(mem_wdata)
	);

	// one word per even address, so bit 0 of the address is dropped
	assign mem_rdata = mem_read ? mem[mem_address[15:1]] : '0;

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic read_stim();
		int fd;
		int fields;
		string line;
		string rest;
		byte tag;
		lc3b_word addr;
		lc3b_word data;
		fd = $fopen(STIM_FILE, "r");
		assert (fd != 0) else fail_run($sformatf("cannot open %s", STIM_FILE));
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 3 || line[0] == "#")
				continue; // blank or comment line
			tag = line[0];
			rest = line.substr(2, line.len() - 1);
			case (tag)
				"P":
				begin
					fields = $sscanf(rest, "%h %h", addr, data);
					assert (fields == 2) else fail_run($sformatf("bad program line: %s", line));
					mem[addr[15:1]] = data;
				end
				"W":
				begin
					fields = $sscanf(rest, "%h %h", addr, data);
					assert (fields == 2) else fail_run($sformatf("bad store line: %s", line));
					exp_addr.push_back(addr);
					exp_data.push_back(data);
				end
				"C":
				begin
					fields = $sscanf(rest, "%d", instr_count);
					assert (fields == 1) else fail_run($sformatf("bad count line: %s", line));
				end
				default: fail_run($sformatf("unknown line in stimulus file: %s", line));
			endcase
		end
		$fclose(fd);
		assert (instr_count > 0 && exp_addr.size() > 0)
		else
			fail_run("stimulus file holds no instruction count or no expected store");
	endtask

	// checks one store against the next expected entry, then commits it
	task automatic handle_store();
		assert (store_count < exp_addr.size())
		else
			fail_run($sformatf("store of %h to address %h was not expected", mem_wdata,
				mem_address));
		assert (mem_address == exp_addr[store_count])
		else
			fail_run($sformatf("FAILED mem_address expected %h actual %h",
				exp_addr[store_count], mem_address));
		assert (mem_wdata == exp_data[store_count])
		else
			fail_run($sformatf("FAILED mem_wdata expected %h actual %h",
				exp_data[store_count], mem_wdata));
		mem[mem_address[15:1]] = mem_wdata;
		store_count++;
	endtask

	initial
	begin
		rst_n = 1'b0;
		instr_count = 0;
		store_count = 0;
		cycles = 0;
		void'($urandom(47));
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = lc3b_word'($urandom());
		read_stim();
		cycle_limit = 20 + 7 * (instr_count + 2); // seven cycles covers the longest instruction

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		cycles = 10;
		while (store_count < exp_addr.size() && cycles < cycle_limit)
		begin
			@(posedge clk);
			cycles++;
			if (rst_n && mem_write)
				handle_store();
		end

		if (store_count == exp_addr.size())
		begin
			// the program now spins on its branch-to-self so any further store is wrong
			repeat (14)
			begin
				@(posedge clk);
				if (mem_write)
					handle_store();
			end
			$display("Testbench passed");
			$finish;
		end
		else
			fail_run($sformatf("timeout after %0d cycles with %0d of %0d stores seen",
				cycles, store_count, exp_addr.size()));
	end

endmodule

`default_nettype wire

/* bench/lc3b_stim.txt */
# P address data: program or data word, W address data: expected store in order
# C n: instructions executed up to and including the last store
P 0000 EC3F
P 0002 1227
P 0004 143D
P 0006 1642
P 0008 7780
P 000A 5842
P 000C 5ABA
P 000E 7981
P 0010 7B82
P 0012 9EFF
P 0014 0401
P 0016 7F83
P 0018 0801
P 001A 7F84
P 001C 1079
P 001E 0201
P 0020 0401
P 0022 7F84
P 0024 1021
P 0026 0201
P 0028 7F84
P 002A 0801
P 002C 63BE
P 002E 7384
P 0030 EA02
P 0032 C140
P 0034 7F85
P 0036 7B85
P 0038 0FFF
P 007C A5C3
W 0080 0004
W 0082 0005
W 0084 FFF8
W 0086 FFFB
W 0088 A5C3
W 008A 0036
C 24

/* sim.f */
+incdir+common
common/lc3b_types.sv
datapath/lc3b_alu.sv
datapath/lc3b_regfile.sv
datapath/lc3b_ir.sv
datapath/lc3b_datapath.sv
control/lc3b_control.sv
verilog/lc3b_cpu.sv
bench/lc3b_cpu_checker.sv
bench/lc3b_cpu_tb.sv

/* Makefile */
# Verilator simulation of the LC-3b core; run from the project root

VERILATOR ?= verilator
TOP ?= lc3b_cpu_tb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
